// ==== list.f ====
src/vita_tx_pkg.sv
src/tx_settings.sv
src/vita_time_counter.sv
src/tx_strobe_gen.sv
src/tx_sample_fifo.sv
src/time_compare.sv
src/vita_tx_control.sv
src/vita_tx_top.sv
verification/vita_tx_tb.sv

// ==== src/time_compare.sv ====
`default_nettype none

module time_compare (
   input  logic [vita_tx_pkg::TIME_W-1:0] time_now_i,
   input  logic [vita_tx_pkg::TIME_W-1:0] trigger_time_i,
   output logic                           now_o,
   output logic                           early_o,
   output logic                           late_o,
   output logic                           too_early_o
);

   logic [vita_tx_pkg::TIME_W-1:0] lead;

   // only meaningful while early.
   assign lead = trigger_time_i - time_now_i;

   assign now_o   = (time_now_i == trigger_time_i);
   assign early_o = (time_now_i < trigger_time_i);
   assign late_o  = (time_now_i > trigger_time_i);

   // too far in the future to wait for.
   assign too_early_o = early_o && (lead > vita_tx_pkg::TOO_EARLY_LIMIT);

endmodule

`default_nettype wire

// ==== src/tx_sample_fifo.sv ====
`default_nettype none

module tx_sample_fifo (
   input  logic                   clk,
   input  logic                   arst_n_i,
   input  logic                   flush_i,
   input  logic                   wr_i,
   input  vita_tx_pkg::tx_entry_t wr_entry_i,
   input  logic                   pop_i,
   output logic                   full_o,
   output logic                   valid_o,
   output vita_tx_pkg::tx_entry_t head_o
);

   localparam int AW = vita_tx_pkg::FIFO_AW;

   vita_tx_pkg::tx_entry_t mem [vita_tx_pkg::FIFO_DEPTH];

   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [AW:0]   count_q;
   logic          do_wr;
   logic          do_pop;

   assign full_o  = (count_q == (AW+1)'(vita_tx_pkg::FIFO_DEPTH));
   assign valid_o = (count_q != '0);
   assign head_o  = mem[rd_ptr_q];  // fall-through head.

   // flush drops both a push and a pop in the same cycle.
   assign do_wr  = wr_i && !full_o && !flush_i;
   assign do_pop = pop_i && valid_o && !flush_i;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else if (flush_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr_q <= wr_ptr_q + AW'(1);
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + AW'(1);
         end
         case ({do_wr, do_pop})
            2'b10:   count_q <= count_q + (AW+1)'(1);
            2'b01:   count_q <= count_q - (AW+1)'(1);
            default: count_q <= count_q;  // both or neither.
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr_q] <= wr_entry_i;
      end
   end

endmodule

`default_nettype wire

// ==== src/tx_settings.sv ====
`default_nettype none

module tx_settings (
   input  logic                             clk,
   input  logic                             arst_n_i,
   input  logic                             set_stb_i,
   input  logic [7:0]                       set_addr_i,
   input  logic [31:0]                      set_data_i,
   output logic [31:0]                      interval_o,
   output logic [vita_tx_pkg::TIME_W-1:0]   time_value_o,
   output logic                             time_load_o,
   output logic                             clear_o
);

   logic                           wr_interval;
   logic                           wr_time_hi;
   logic                           wr_time_lo;
   logic                           wr_clear;
   logic [31:0]                    interval_q;
   logic [31:0]                    time_hi_q;
   logic [vita_tx_pkg::TIME_W-1:0] time_value_q;
   logic                           time_load_q;
   logic                           clear_q;

   // register decode.
   assign wr_interval = set_stb_i &&
      (set_addr_i == vita_tx_pkg::TX_CTRL_BASE + vita_tx_pkg::SR_INTERVAL);
   assign wr_time_hi = set_stb_i &&
      (set_addr_i == vita_tx_pkg::TX_CTRL_BASE + vita_tx_pkg::SR_TIME_HI);
   assign wr_time_lo = set_stb_i &&
      (set_addr_i == vita_tx_pkg::TX_CTRL_BASE + vita_tx_pkg::SR_TIME_LO);
   assign wr_clear = set_stb_i &&
      (set_addr_i == vita_tx_pkg::TX_CTRL_BASE + vita_tx_pkg::SR_CLEAR);

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         interval_q  <= vita_tx_pkg::STROBE_INTERVAL_RST;
         time_load_q <= 1'b0;
         clear_q     <= 1'b0;
      end else begin
         if (wr_interval) begin
            interval_q <= set_data_i;
         end
         time_load_q <= wr_time_lo;  // one-cycle command pulses.
         clear_q     <= wr_clear;
      end
   end

   // upper half waits here for the lower half.
   always_ff @(posedge clk) begin
      if (wr_time_hi) begin
         time_hi_q <= set_data_i;
      end
      if (wr_time_lo) begin
         time_value_q <= {time_hi_q, set_data_i};
      end
   end

   assign interval_o   = interval_q;
   assign time_value_o = time_value_q;
   assign time_load_o  = time_load_q;
   assign clear_o      = clear_q;

endmodule

`default_nettype wire

// ==== src/tx_strobe_gen.sv ====
`default_nettype none

module tx_strobe_gen (
   input  logic        clk,
   input  logic        arst_n_i,
   input  logic [31:0] interval_i,
   output logic        strobe_o
);

   logic [31:0] cnt_q;
   logic        strobe_q;

   // strobe once, then interval_i quiet cycles.
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q    <= '0;
         strobe_q <= 1'b0;
      end else if (cnt_q == '0) begin
         cnt_q    <= interval_i;  // reload picks up a new interval.
         strobe_q <= 1'b1;
      end else begin
         cnt_q    <= cnt_q - 32'd1;
         strobe_q <= 1'b0;
      end
   end

   assign strobe_o = strobe_q;

endmodule

`default_nettype wire

// ==== src/vita_time_counter.sv ====
`default_nettype none

module vita_time_counter (
   input  logic                           clk,
   input  logic                           arst_n_i,
   input  logic                           time_load_i,
   input  logic [vita_tx_pkg::TIME_W-1:0] time_value_i,
   output logic [vita_tx_pkg::TIME_W-1:0] vita_time_o
);

   logic [vita_tx_pkg::TIME_W-1:0] vita_time_q;

   // free-running, one tick per clock.
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         vita_time_q <= '0;
      end else if (time_load_i) begin
         vita_time_q <= time_value_i;  // load wins over the increment.
      end else begin
         vita_time_q <= vita_time_q + vita_tx_pkg::TIME_W'(1);
      end
   end

   assign vita_time_o = vita_time_q;

endmodule

`default_nettype wire

// ==== src/vita_tx_control.sv ====
`default_nettype none

module vita_tx_control (
   input  logic                             clk,
   input  logic                             arst_n_i,
   input  logic                             clear_i,
   input  logic                             head_valid_i,
   input  vita_tx_pkg::tx_entry_t           head_i,
   input  logic                             now_i,
   input  logic                             late_i,
   input  logic                             too_early_i,
   input  logic                             strobe_i,
   output logic                             pop_o,
   output logic [vita_tx_pkg::SAMPLE_W-1:0] sample_o,
   output logic                             run_o,
   output logic                             underrun_o
);

   typedef enum logic [1:0] {
      ST_IDLE     = 2'd0,
      ST_RUN      = 2'd1,
      ST_UNDERRUN = 2'd2
   } state_t;

   state_t state_q;
   state_t state_d;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (head_valid_i) begin
               if (!head_i.send_at || now_i) begin
                  state_d = ST_RUN;
               end else if (late_i || too_early_i) begin
                  state_d = ST_UNDERRUN;  // missed or unreachable send time.
               end
            end
         end
         ST_RUN: begin
            if (strobe_i) begin
               if (!head_valid_i) begin
                  state_d = ST_UNDERRUN;  // starved mid-burst.
               end else if (head_i.eob) begin
                  state_d = ST_IDLE;
               end
            end
         end
         default: begin
            state_d = ST_UNDERRUN;  // sticky until clear.
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_IDLE;
      end else if (clear_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // the DSP side takes the head sample on each strobe while running.
   assign pop_o      = strobe_i && (state_q == ST_RUN);
   assign sample_o   = head_i.sample;
   assign run_o      = (state_q == ST_RUN);
   assign underrun_o = (state_q == ST_UNDERRUN);

endmodule

`default_nettype wire

// ==== src/vita_tx_pkg.sv ====
`default_nettype none

package vita_tx_pkg;

   // datapath sizing.
   localparam int SAMPLE_W   = 32;
   localparam int TIME_W     = 64;
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW    = 4;

   // largest lead of a send time over the current time.
   localparam logic [TIME_W-1:0] TOO_EARLY_LIMIT = 64'd1 << 20;

   // settings bus map, offsets relative to the base.
   localparam logic [7:0] TX_CTRL_BASE = 8'h10;
   localparam logic [7:0] SR_INTERVAL  = 8'd0;  // strobe interval minus one.
   localparam logic [7:0] SR_TIME_HI   = 8'd1;
   localparam logic [7:0] SR_TIME_LO   = 8'd2;  // commits the time load.
   localparam logic [7:0] SR_CLEAR     = 8'd3;

   localparam logic [31:0] STROBE_INTERVAL_RST = 32'd3;

   // one transmit entry as pushed by the host.
   typedef struct packed {
      logic                send_at;    // hold until send_time.
      logic                sob;
      logic                eob;
      logic                eop;        // carried only.
      logic [TIME_W-1:0]   send_time;
      logic [SAMPLE_W-1:0] sample;
   } tx_entry_t;

endpackage

`default_nettype wire

// ==== src/vita_tx_top.sv ====
`default_nettype none

module vita_tx_top (
   input  logic                             clk,
   input  logic                             arst_n_i,
   input  logic                             set_stb_i,
   input  logic [7:0]                       set_addr_i,
   input  logic [31:0]                      set_data_i,
   input  logic                             sample_wr_i,
   input  vita_tx_pkg::tx_entry_t           sample_entry_i,
   output logic                             sample_full_o,
   output logic [vita_tx_pkg::SAMPLE_W-1:0] sample_o,
   output logic                             run_o,
   output logic                             underrun_o,
   output logic                             strobe_o,
   output logic [vita_tx_pkg::TIME_W-1:0]   vita_time_o
);

   logic [31:0]                    interval;
   logic [vita_tx_pkg::TIME_W-1:0] time_value;
   logic                           time_load;
   logic                           clear;
   logic [vita_tx_pkg::TIME_W-1:0] vita_time;
   logic                           strobe;
   logic                           head_valid;
   vita_tx_pkg::tx_entry_t         head_entry;
   logic                           pop;
   logic                           now;
   logic                           late;
   logic                           too_early;

   tx_settings tx_settings_i (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .set_stb_i    (set_stb_i),
      .set_addr_i   (set_addr_i),
      .set_data_i   (set_data_i),
      .interval_o   (interval),
      .time_value_o (time_value),
      .time_load_o  (time_load),
      .clear_o      (clear)
   );

   vita_time_counter vita_time_counter_i (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .time_load_i  (time_load),
      .time_value_i (time_value),
      .vita_time_o  (vita_time)
   );

   tx_strobe_gen tx_strobe_gen_i (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .interval_i (interval),
      .strobe_o   (strobe)
   );

   tx_sample_fifo tx_sample_fifo_i (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .flush_i    (clear),
      .wr_i       (sample_wr_i),
      .wr_entry_i (sample_entry_i),
      .pop_i      (pop),
      .full_o     (sample_full_o),
      .valid_o    (head_valid),
      .head_o     (head_entry)
   );

   // early is implied by the other verdicts, control does not need it.
   time_compare time_compare_i (
      .time_now_i     (vita_time),
      .trigger_time_i (head_entry.send_time),
      .now_o          (now),
      .early_o        (),
      .late_o         (late),
      .too_early_o    (too_early)
   );

   vita_tx_control vita_tx_control_i (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .clear_i      (clear),
      .head_valid_i (head_valid),
      .head_i       (head_entry),
      .now_i        (now),
      .late_i       (late),
      .too_early_i  (too_early),
      .strobe_i     (strobe),
      .pop_o        (pop),
      .sample_o     (sample_o),
      .run_o        (run_o),
      .underrun_o   (underrun_o)
   );

   assign strobe_o    = strobe;
   assign vita_time_o = vita_time;

endmodule

`default_nettype wire

// ==== verification/vita_tx_tb.sv ====
`default_nettype none

module vita_tx_tb;

   localparam int NUM_ROWS      = 7;
   localparam int ROW_CYCLES    = 400;  // longest row with margin.
   localparam int SETTLE        = 8;
   localparam int WATCHDOG_TIME = (NUM_ROWS * ROW_CYCLES + 20) * 10;

   localparam logic [1:0] SET_NONE     = 2'd0;
   localparam logic [1:0] SET_INTERVAL = 2'd1;
   localparam logic [1:0] SET_TIME     = 2'd2;

   // one scenario: entries to push, one setting write, expected end state.
   typedef struct packed {
      logic [4:0]  n_entries;
      logic        send_at;
      logic        eob_last;
      logic [31:0] time_offset;  // signed, from vita_time_o at the push.
      logic [1:0]  set_kind;
      logic [63:0] set_value;
      logic        exp_run;
      logic        exp_underrun;
      logic [4:0]  exp_left;     // samples still buffered at the end.
   } row_t;

   logic                                  clk;
   logic                                  arst_n_i;
   logic                                  set_stb_i;
   logic [7:0]                            set_addr_i;
   logic [31:0]                           set_data_i;
   logic                                  sample_wr_i;
   vita_tx_pkg::tx_entry_t                sample_entry_i;
   logic                                  sample_full_o;
   logic [vita_tx_pkg::SAMPLE_W-1:0]      sample_o;
   logic                                  run_o;
   logic                                  underrun_o;
   logic                                  strobe_o;
   logic [vita_tx_pkg::TIME_W-1:0]        vita_time_o;

   row_t        rows [NUM_ROWS];
   logic [31:0] model_q [$];
   logic        starved;
   logic [31:0] lfsr_q;

   vita_tx_top vita_tx_top_i (
      .clk            (clk),
      .arst_n_i       (arst_n_i),
      .set_stb_i      (set_stb_i),
      .set_addr_i     (set_addr_i),
      .set_data_i     (set_data_i),
      .sample_wr_i    (sample_wr_i),
      .sample_entry_i (sample_entry_i),
      .sample_full_o  (sample_full_o),
      .sample_o       (sample_o),
      .run_o          (run_o),
      .underrun_o     (underrun_o),
      .strobe_o       (strobe_o),
      .vita_time_o    (vita_time_o)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;  // taps 32, 22, 2, 1.
      end
      return n;
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
   endtask

   task automatic fail_and_stop();
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         $display("Error: time %0t, %s expected %0h, actual %0h", $time, name, expected, actual);
         fail_and_stop();
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic write_setting(input logic [7:0] offset, input logic [31:0] data);
      set_stb_i  = 1'b1;
      set_addr_i = vita_tx_pkg::TX_CTRL_BASE + offset;
      set_data_i = data;
      next_cycle();
      set_stb_i  = 1'b0;
   endtask

   task automatic apply_clear();
      write_setting(vita_tx_pkg::SR_CLEAR, 32'd0);
      next_cycle();  // flush and state reset land on this edge.
      model_q.delete();
      starved = 1'b0;
      check_value("run_o", 0, run_o);
      check_value("underrun_o", 0, underrun_o);
      check_value("sample_full_o", 0, sample_full_o);
   endtask

   task automatic apply_setting(input row_t row);
      int gap;
      if (row.set_kind == SET_TIME) begin
         write_setting(vita_tx_pkg::SR_TIME_HI, row.set_value[63:32]);
         write_setting(vita_tx_pkg::SR_TIME_LO, row.set_value[31:0]);
         next_cycle();
         check_value("vita_time_o", row.set_value, vita_time_o);
      end else if (row.set_kind == SET_INTERVAL) begin
         write_setting(vita_tx_pkg::SR_INTERVAL, row.set_value[31:0]);
         do next_cycle(); while (!strobe_o);  // first strobe on the new interval.
         gap = 0;
         do begin
            next_cycle();
            gap++;
         end while (!strobe_o);
         check_value("strobe period", row.set_value + 64'd1, gap);
      end
   endtask

   task automatic push_entries(input row_t row, output logic [63:0] first_time);
      vita_tx_pkg::tx_entry_t e;
      logic [31:0]            smp;
      for (int i = 0; i < row.n_entries; i++) begin
         draw_bits(32, smp);
         e           = '0;
         e.send_at   = row.send_at;
         e.sob       = (i == 0);
         e.eob       = row.eob_last && (i == row.n_entries - 1);
         e.eop       = e.eob;
         e.send_time = vita_time_o + {{32{row.time_offset[31]}}, row.time_offset};
         e.sample    = smp;
         if (i == 0) begin
            first_time = e.send_time;
         end
         sample_entry_i = e;
         sample_wr_i    = 1'b1;
         next_cycle();
         model_q.push_back(smp);  // visible in the buffer from this edge on.
      end
      sample_wr_i = 1'b0;
   endtask

   // run must wait for the send time and start on the cycle after it.
   task automatic check_timed_start(input logic [63:0] send_time);
      while (vita_time_o != send_time) begin
         check_value("run_o", 0, run_o);
         next_cycle();
      end
      check_value("run_o", 0, run_o);
      next_cycle();
      check_value("run_o", 1, run_o);
   endtask

   task automatic wait_final_state(input row_t row);
      while (run_o !== row.exp_run || underrun_o !== row.exp_underrun ||
             model_q.size() != row.exp_left) begin
         next_cycle();
      end
      repeat (SETTLE) next_cycle();
      check_value("run_o", row.exp_run, run_o);
      check_value("underrun_o", row.exp_underrun, underrun_o);
      check_value("queued samples", row.exp_left, model_q.size());
      check_value("sample_full_o", row.exp_left == vita_tx_pkg::FIFO_DEPTH, sample_full_o);
      // only an immediate burst can underrun by starving.
      check_value("starved", row.exp_underrun && !row.send_at, starved);
   endtask

   // each strobe while running hands the oldest pushed sample to the DSP.
   always @(negedge clk) begin
      if (arst_n_i && strobe_o && run_o) begin
         if (model_q.size() == 0) begin
            starved = 1'b1;
         end else begin
            check_value("sample_o", model_q.pop_front(), sample_o);
         end
      end
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("Watchdog expired: the DUT stalled before all rows finished");
      fail_and_stop();
   end

   initial begin
      row_t        row;
      logic [63:0] first_time;
      clk            = 1'b0;
      arst_n_i       = 1'b0;
      set_stb_i      = 1'b0;
      set_addr_i     = '0;
      set_data_i     = '0;
      sample_wr_i    = 1'b0;
      sample_entry_i = '0;
      starved        = 1'b0;
      lfsr_q         = 32'hb774aaa8;
      // n, send_at, eob_last, offset, set_kind, set_value, run, underrun, left.
      rows[0] = '{5'd4, 1'b0, 1'b1, 32'd0, SET_NONE, 64'd0, 1'b0, 1'b0, 5'd0};
      rows[1] = '{5'd1, 1'b1, 1'b1, 32'd50, SET_TIME, 64'h0000_0123_0000_4000,
                  1'b0, 1'b0, 5'd0};
      rows[2] = '{5'd1, 1'b1, 1'b1, -32'sd10, SET_NONE, 64'd0, 1'b0, 1'b1, 5'd1};
      rows[3] = '{5'd2, 1'b0, 1'b1, 32'd0, SET_NONE, 64'd0, 1'b0, 1'b0, 5'd0};
      rows[4] = '{5'd1, 1'b1, 1'b1, 32'd1049576, SET_NONE, 64'd0, 1'b0, 1'b1, 5'd1};
      rows[5] = '{5'd2, 1'b0, 1'b0, 32'd0, SET_INTERVAL, 64'd5, 1'b0, 1'b1, 5'd0};
      rows[6] = '{5'd16, 1'b1, 1'b0, 32'd5000, SET_NONE, 64'd0, 1'b0, 1'b0, 5'd16};
      repeat (4) @(posedge clk);
      #1;
      arst_n_i = 1'b1;
      check_value("run_o", 0, run_o);
      check_value("underrun_o", 0, underrun_o);
      check_value("strobe_o", 0, strobe_o);
      check_value("sample_full_o", 0, sample_full_o);
      check_value("vita_time_o", 0, vita_time_o);
      for (int r = 0; r < NUM_ROWS; r++) begin
         row = rows[r];
         apply_clear();
         apply_setting(row);
         push_entries(row, first_time);
         if (row.send_at && !row.exp_underrun && row.exp_left == 0) begin
            check_timed_start(first_time);
         end
         wait_final_state(row);
      end
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire
